// ==== compile.f ====
rtl/qspi_mem_pkg.sv
rtl/axil_req_frontend.sv
rtl/req_fifo.sv
rtl/qspi_sequencer.sv
rtl/dqs_read_capture.sv
rtl/qspi_mem_top.sv
tb/qspi_psram_model.sv
tb/qspi_mem_properties.sv
tb/tb_qspi_mem.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_qspi_mem -f compile.f > build.log 2>&1 \
    || { cat build.log; echo "verilator build failed"; exit 1; }
./obj_dir/Vtb_qspi_mem +verilator+error+limit+1000 > sim.log 2>&1 \
    || { cat sim.log; echo "simulation exited with an error"; exit 1; }
cat sim.log
grep -q "sim failed" sim.log && exit 1 || exit 0

// ==== tb/tb_qspi_mem.sv ====
`timescale 1ns/100ps

module tb_qspi_mem;
    import qspi_mem_pkg::*;

    localparam int WAIT_LIMIT = 4000;  // clk cycles per wait

    typedef struct packed {
        logic [1:0]  resp;
        logic [31:0] data;
        logic        check_data;
    } exp_rsp_t;

    logic        clk;
    logic        nrst;
    logic [31:0] s_awaddr;
    logic        s_awvalid;
    logic        s_awready;
    logic [31:0] s_wdata;
    logic [3:0]  s_wstrb;
    logic        s_wvalid;
    logic        s_wready;
    logic [1:0]  s_bresp;
    logic        s_bvalid;
    logic        s_bready;
    logic [31:0] s_araddr;
    logic        s_arvalid;
    logic        s_arready;
    logic [31:0] s_rdata;
    logic [1:0]  s_rresp;
    logic        s_rvalid;
    logic        s_rready;
    logic        spi_csn;
    logic        spi_clk;
    logic [3:0]  spi_mosi;
    logic [3:0]  spi_miso;
    logic        spi_dqs;

    logic [31:0] shadow [MEM_WORDS];
    exp_rsp_t    exp_b [$];
    exp_rsp_t    exp_r [$];
    logic        pins_quiet;  // chip select must stay high
    logic        timed_out;
    int          check_cnt;
    int          mismatch_cnt;
    int          other_cnt;

    qspi_mem_top u_qspi_mem_top (
        .clk_i       (clk),
        .nrst_i      (nrst),
        .s_awaddr_i  (s_awaddr),
        .s_awvalid_i (s_awvalid),
        .s_awready_o (s_awready),
        .s_wdata_i   (s_wdata),
        .s_wstrb_i   (s_wstrb),
        .s_wvalid_i  (s_wvalid),
        .s_wready_o  (s_wready),
        .s_bresp_o   (s_bresp),
        .s_bvalid_o  (s_bvalid),
        .s_bready_i  (s_bready),
        .s_araddr_i  (s_araddr),
        .s_arvalid_i (s_arvalid),
        .s_arready_o (s_arready),
        .s_rdata_o   (s_rdata),
        .s_rresp_o   (s_rresp),
        .s_rvalid_o  (s_rvalid),
        .s_rready_i  (s_rready),
        .spi_csn_o   (spi_csn),
        .spi_clk_o   (spi_clk),
        .spi_mosi_o  (spi_mosi),
        .spi_miso_i  (spi_miso),
        .spi_dqs_i   (spi_dqs)
    );

    qspi_psram_model u_model (
        .clk_i      (clk),
        .nrst_i     (nrst),
        .spi_csn_i  (spi_csn),
        .spi_clk_i  (spi_clk),
        .spi_mosi_i (spi_mosi),
        .spi_miso_o (spi_miso),
        .spi_dqs_o  (spi_dqs)
    );

    always #10 clk = ~clk;

    // shadow memory is updated in issue order
    function automatic exp_rsp_t expected_response(logic is_write, logic [31:0] addr,
                                                   logic [31:0] data);
        exp_rsp_t e;
        logic [29:0] word;
        word         = addr[31:2];
        e.data       = '0;
        e.check_data = !is_write;
        if (word >= 30'(MEM_WORDS)) begin
            e.resp       = 2'b10;
            e.check_data = 1'b0;
        end else begin
            e.resp = 2'b00;
            if (is_write) shadow[word[9:0]] = data;
            else e.data = shadow[word[9:0]];
        end
        return e;
    endfunction

    task automatic compare(string name, logic [31:0] got, logic [31:0] exp);
        check_cnt++;
        if (got !== exp) begin
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
            mismatch_cnt++;
        end
    endtask

    task automatic finish_run();
        $display("checks %0d mismatches %0d other failures %0d assertion failures %0d",
                 check_cnt, mismatch_cnt, other_cnt, u_qspi_mem_top.u_props.fail_cnt);
        if (mismatch_cnt == 0 && other_cnt == 0 && check_cnt > 0 &&
            u_qspi_mem_top.u_props.fail_cnt == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    endtask

    task automatic report_timeout(string what);
        $display("timeout at %0t: %s did not happen within %0d cycles", $time, what, WAIT_LIMIT);
        other_cnt++;
        timed_out = 1'b1;
    endtask

    task automatic check_idle_pins();
        compare("spi_csn_o", 32'(spi_csn), 32'h1);
        compare("spi_clk_o", 32'(spi_clk), 32'h0);
        compare("s_awready_o", 32'(s_awready), 32'h0);
        compare("s_wready_o", 32'(s_wready), 32'h0);
        compare("s_arready_o", 32'(s_arready), 32'h0);
        compare("s_bvalid_o", 32'(s_bvalid), 32'h0);
        compare("s_rvalid_o", 32'(s_rvalid), 32'h0);
    endtask

    task automatic issue_request(logic is_write, logic [31:0] addr, logic [31:0] data);
        int n;
        if (timed_out) return;
        if (is_write) exp_b.push_back(expected_response(1'b1, addr, data));
        else exp_r.push_back(expected_response(1'b0, addr, data));
        @(posedge clk);
        if (is_write) begin
            s_awaddr  <= addr;
            s_wdata   <= data;
            s_awvalid <= 1'b1;
            s_wvalid  <= 1'b1;
        end else begin
            s_araddr  <= addr;
            s_arvalid <= 1'b1;
        end
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!(is_write ? s_awready : s_arready) && n < WAIT_LIMIT);
        if (!(is_write ? s_awready : s_arready)) begin
            report_timeout("request acceptance");
        end else if (is_write) begin
            compare("s_wready_o", 32'(s_wready), 32'h1);
        end
        s_awvalid <= 1'b0;
        s_wvalid  <= 1'b0;
        s_arvalid <= 1'b0;
    endtask

    task automatic drain_responses();
        int n;
        if (timed_out) return;
        n = 0;
        while ((exp_b.size() != 0 || exp_r.size() != 0) && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (exp_b.size() != 0 || exp_r.size() != 0) report_timeout("all responses");
    endtask

    // response checker on the B and R handshakes
    always @(posedge clk) begin
        exp_rsp_t e;
        if (nrst && s_bvalid && s_bready) begin
            if (exp_b.size() == 0) begin
                $display("unexpected write response at %0t", $time);
                other_cnt++;
            end else begin
                e = exp_b.pop_front();
                compare("s_bresp_o", 32'(s_bresp), 32'(e.resp));
            end
        end
        if (nrst && s_rvalid && s_rready) begin
            if (exp_r.size() == 0) begin
                $display("unexpected read response at %0t", $time);
                other_cnt++;
            end else begin
                e = exp_r.pop_front();
                compare("s_rresp_o", 32'(s_rresp), 32'(e.resp));
                if (e.check_data) compare("s_rdata_o", s_rdata, e.data);
            end
        end
        if (pins_quiet) compare("spi_csn_o", 32'(spi_csn), 32'h1);
    end

    initial begin
        logic [31:0] word;
        logic [31:0] data;
        logic        wr;
        int          n;
        void'($urandom(32'h2b9dc77e));
        clk          = 1'b0;
        nrst         = 1'b0;
        s_awaddr     = '0;
        s_awvalid    = 1'b0;
        s_wdata      = '0;
        s_wstrb      = 4'hf;  // full words only
        s_wvalid     = 1'b0;
        s_bready     = 1'b1;
        s_araddr     = '0;
        s_arvalid    = 1'b0;
        s_rready     = 1'b1;
        pins_quiet   = 1'b0;
        timed_out    = 1'b0;
        check_cnt    = 0;
        mismatch_cnt = 0;
        other_cnt    = 0;

        repeat (16) @(posedge clk);
        check_idle_pins();
        nrst <= 1'b1;
        @(posedge clk);
        check_idle_pins();
        for (int i = 0; i < MEM_WORDS; i++) begin
            shadow[i] = u_model.mem[i];  // device starts with its fill pattern
        end

        // write then read back
        issue_request(1'b1, 32'h0000_0124, 32'hcafe_f00d);
        issue_request(1'b0, 32'h0000_0124, 32'h0);
        drain_responses();

        // device array holds the word at the decoded row and column
        word = $urandom_range(MEM_WORDS - 1, 0);
        data = $urandom;
        issue_request(1'b1, {word[29:0], 2'b00}, data);
        drain_responses();
        compare("model mem", u_model.mem[word[9:0]], data);

        // out of range requests leave the device idle
        pins_quiet = 1'b1;
        issue_request(1'b1, 32'(MEM_WORDS * 4), 32'h1234_5678);
        issue_request(1'b0, 32'h8000_0010, 32'h0);
        drain_responses();
        pins_quiet = 1'b0;

        // hold both response channels and stack requests up
        @(posedge clk);
        s_bready <= 1'b0;
        s_rready <= 1'b0;
        issue_request(1'b1, 32'h0000_0040, 32'h1111_2222);
        issue_request(1'b0, 32'h0000_0040, 32'h0);
        issue_request(1'b1, 32'h0000_0ffc, 32'h3333_4444);
        issue_request(1'b0, 32'h0000_0ffc, 32'h0);
        n = 0;
        while (!timed_out && !(s_bvalid && s_rvalid) && n < WAIT_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (!timed_out && !(s_bvalid && s_rvalid)) report_timeout("held responses");
        repeat (40) @(posedge clk);
        s_bready <= 1'b1;
        s_rready <= 1'b1;
        drain_responses();

        // random traffic with some out of range accesses
        repeat (200) begin
            wr   = 1'($urandom_range(1, 0));
            word = ($urandom_range(15, 0) == 0) ? 32'(MEM_WORDS) + $urandom_range(255, 0) :
                   $urandom_range(MEM_WORDS - 1, 0);
            data = $urandom;
            issue_request(wr, {word[29:0], 2'b00}, data);
        end
        drain_responses();
        finish_run();
    end

endmodule

// ==== tb/qspi_mem_properties.sv ====
`timescale 1ns/100ps

module qspi_mem_properties (
    input logic        clk_i,
    input logic        nrst_i,
    input logic        spi_csn_i,
    input logic        spi_clk_i,
    input logic        rvalid_i,
    input logic        rready_i,
    input logic [31:0] rdata_i,
    input logic        bvalid_i,
    input logic        bready_i
);
    int fail_cnt = 0;

    csn_clk_a: assert property (@(posedge clk_i) disable iff (!nrst_i)
        spi_csn_i |-> !spi_clk_i)
    else begin
        $error("spi clock high while chip select is high");
        fail_cnt++;
    end

    r_hold_a: assert property (@(posedge clk_i) disable iff (!nrst_i)
        rvalid_i && !rready_i |=> rvalid_i && $stable(rdata_i))
    else begin
        $error("read response changed while rready low");
        fail_cnt++;
    end

    b_hold_a: assert property (@(posedge clk_i) disable iff (!nrst_i)
        bvalid_i && !bready_i |=> bvalid_i)
    else begin
        $error("write response dropped while bready low");
        fail_cnt++;
    end

endmodule

bind qspi_mem_top qspi_mem_properties u_props (
    .clk_i     (clk_i),
    .nrst_i    (nrst_i),
    .spi_csn_i (spi_csn_o),
    .spi_clk_i (spi_clk_o),
    .rvalid_i  (s_rvalid_o),
    .rready_i  (s_rready_i),
    .rdata_i   (s_rdata_o),
    .bvalid_i  (s_bvalid_o),
    .bready_i  (s_bready_i)
);

// ==== tb/qspi_psram_model.sv ====
`timescale 1ns/100ps

module qspi_psram_model (
    input  logic       clk_i,
    input  logic       nrst_i,
    input  logic       spi_csn_i,
    input  logic       spi_clk_i,
    input  logic [3:0] spi_mosi_i,
    output logic [3:0] spi_miso_o,
    output logic       spi_dqs_o
);
    import qspi_mem_pkg::*;

    localparam int ADDR_END  = 2 + NIBBLES_PER_WORD;  // spi periods of command and address
    localparam int DATA_BEG  = ADDR_END + LATENCY_CYCLES;
    localparam int DATA_STEP = 2 * PREAMBLE_EDGES;
    localparam int STEP_LAST = DATA_STEP + NIBBLES_PER_WORD - 1;

    logic [31:0] mem [MEM_WORDS];
    logic [7:0]  cmd;
    logic [31:0] aw;
    logic [31:0] wd;
    logic [31:0] rd_word;
    logic [22:0] idx;
    logic        reading;
    int          phase;
    int          step;
    int          hold;

    assign idx        = {aw[28:16], aw[14:5]};  // row then column
    assign spi_dqs_o  = reading && step[0];
    assign spi_miso_o = (reading && step >= DATA_STEP) ?
                        rd_word[4 * (step - DATA_STEP) +: 4] : 4'h0;

    always @(posedge clk_i or negedge nrst_i) begin
        if (!nrst_i) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= {~i[15:0], i[15:0] ^ 16'h5ac3};
            end
            cmd     <= '0;
            aw      <= '0;
            wd      <= '0;
            rd_word <= '0;
            reading <= 1'b0;
            phase   <= 0;
            step    <= 0;
            hold    <= 0;
        end else begin
            if (reading) begin
                hold <= (hold == 3) ? 0 : hold + 1;  // four clocks per strobe level
                if (hold == 3) begin
                    step <= step + 1;
                    if (step == STEP_LAST) reading <= 1'b0;
                end
            end
            if (spi_csn_i) begin
                phase <= 0;
            end else if (spi_clk_i) begin
                phase <= phase + 1;
                if (phase < 2) cmd <= {cmd[3:0], spi_mosi_i};
                else if (phase < ADDR_END) aw <= {aw[27:0], spi_mosi_i};
                else if (phase >= DATA_BEG) wd <= {spi_mosi_i, wd[31:4]};  // lsb nibble first
                if (cmd == 8'(CMD_WRITE) && phase == DATA_BEG + NIBBLES_PER_WORD - 1 &&
                    idx < 23'(MEM_WORDS)) begin
                    mem[idx[9:0]] <= {spi_mosi_i, wd[31:4]};
                end
                if (cmd == 8'(CMD_READ) && phase == DATA_BEG - 1 && idx < 23'(MEM_WORDS)) begin
                    rd_word <= mem[idx[9:0]];
                    reading <= 1'b1;
                    step    <= 0;
                    hold    <= 0;
                end
            end
        end
    end

endmodule

// ==== rtl/qspi_mem_top.sv ====
`timescale 1ns/100ps

module qspi_mem_top (
    input  logic        clk_i,
    input  logic        nrst_i,

    input  logic [31:0] s_awaddr_i,
    input  logic        s_awvalid_i,
    output logic        s_awready_o,
    input  logic [31:0] s_wdata_i,
    input  logic [3:0]  s_wstrb_i,
    input  logic        s_wvalid_i,
    output logic        s_wready_o,
    output logic [1:0]  s_bresp_o,
    output logic        s_bvalid_o,
    input  logic        s_bready_i,
    input  logic [31:0] s_araddr_i,
    input  logic        s_arvalid_i,
    output logic        s_arready_o,
    output logic [31:0] s_rdata_o,
    output logic [1:0]  s_rresp_o,
    output logic        s_rvalid_o,
    input  logic        s_rready_i,

    output logic        spi_csn_o,
    output logic        spi_clk_o,
    output logic [3:0]  spi_mosi_o,
    input  logic [3:0]  spi_miso_i,
    input  logic        spi_dqs_i
);
    import qspi_mem_pkg::*;

    mem_req_t fe_req;
    logic     fe_req_valid;
    logic     fe_req_ready;
    mem_req_t seq_req;
    logic     seq_req_valid;
    logic     seq_req_ready;
    mem_rsp_t rsp;
    logic     rsp_valid;
    logic     rsp_ready;
    logic     cap_en;
    data_w    rd_data;
    logic     rd_valid;

    axil_req_frontend u_frontend (
        .clk_i       (clk_i),
        .nrst_i      (nrst_i),
        .s_awaddr_i  (s_awaddr_i),
        .s_awvalid_i (s_awvalid_i),
        .s_awready_o (s_awready_o),
        .s_wdata_i   (s_wdata_i),
        .s_wstrb_i   (s_wstrb_i),
        .s_wvalid_i  (s_wvalid_i),
        .s_wready_o  (s_wready_o),
        .s_bresp_o   (s_bresp_o),
        .s_bvalid_o  (s_bvalid_o),
        .s_bready_i  (s_bready_i),
        .s_araddr_i  (s_araddr_i),
        .s_arvalid_i (s_arvalid_i),
        .s_arready_o (s_arready_o),
        .s_rdata_o   (s_rdata_o),
        .s_rresp_o   (s_rresp_o),
        .s_rvalid_o  (s_rvalid_o),
        .s_rready_i  (s_rready_i),
        .req_o       (fe_req),
        .req_valid_o (fe_req_valid),
        .req_ready_i (fe_req_ready),
        .rsp_i       (rsp),
        .rsp_valid_i (rsp_valid),
        .rsp_ready_o (rsp_ready)
    );

    req_fifo #(
        .DEPTH (REQ_FIFO_DEPTH)
    ) u_fifo (
        .clk_i        (clk_i),
        .nrst_i       (nrst_i),
        .push_data_i  (fe_req),
        .push_valid_i (fe_req_valid),
        .push_ready_o (fe_req_ready),
        .pop_data_o   (seq_req),
        .pop_valid_o  (seq_req_valid),
        .pop_ready_i  (seq_req_ready)
    );

    qspi_sequencer u_seq (
        .clk_i       (clk_i),
        .nrst_i      (nrst_i),
        .req_i       (seq_req),
        .req_valid_i (seq_req_valid),
        .req_ready_o (seq_req_ready),
        .rsp_o       (rsp),
        .rsp_valid_o (rsp_valid),
        .rsp_ready_i (rsp_ready),
        .cap_en_o    (cap_en),
        .rd_data_i   (rd_data),
        .rd_valid_i  (rd_valid),
        .spi_csn_o   (spi_csn_o),
        .spi_clk_o   (spi_clk_o),
        .spi_mosi_o  (spi_mosi_o)
    );

    dqs_read_capture u_cap (
        .clk_i      (clk_i),
        .nrst_i     (nrst_i),
        .cap_en_i   (cap_en),
        .spi_dqs_i  (spi_dqs_i),
        .spi_miso_i (spi_miso_i),
        .rd_data_o  (rd_data),
        .rd_valid_o (rd_valid)
    );

endmodule

// ==== rtl/dqs_read_capture.sv ====
`timescale 1ns/100ps

module dqs_read_capture (
    input  logic                clk_i,
    input  logic                nrst_i,
    input  logic                cap_en_i,
    input  logic                spi_dqs_i,
    input  logic [3:0]          spi_miso_i,
    output qspi_mem_pkg::data_w rd_data_o,
    output logic                rd_valid_o
);
    import qspi_mem_pkg::*;

    cap_state_e                          state;
    logic [1:0]                          dqs_sync;
    logic [1:0][3:0]                     miso_sync;
    logic                                dqs_prev;
    logic                                dqs_edge;
    logic                                dqs_rise;
    logic [$clog2(PREAMBLE_EDGES)-1:0]   pre_cnt;
    logic [$clog2(NIBBLES_PER_WORD)-1:0] nib_cnt;

    assign dqs_edge = dqs_sync[1] ^ dqs_prev;
    assign dqs_rise = dqs_edge && dqs_sync[1];

    always_ff @(posedge clk_i or negedge nrst_i) begin
        if (!nrst_i) begin
            dqs_sync   <= '0;
            miso_sync  <= '0;
            dqs_prev   <= 1'b0;
            state      <= OFF;
            pre_cnt    <= '0;
            nib_cnt    <= '0;
            rd_valid_o <= 1'b0;
        end else begin
            dqs_sync   <= {dqs_sync[0], spi_dqs_i};
            miso_sync  <= {miso_sync[0], spi_miso_i};  // same delay as the strobe
            dqs_prev   <= dqs_sync[1];
            rd_valid_o <= 1'b0;
            if (!cap_en_i) begin
                state <= OFF;
            end else begin
                case (state)
                    OFF: begin
                        pre_cnt <= '0;
                        state   <= PREAMBLE;
                    end
                    PREAMBLE: begin
                        if (dqs_rise) begin
                            pre_cnt <= pre_cnt + 1'b1;
                            if (int'(pre_cnt) == PREAMBLE_EDGES - 1) begin
                                nib_cnt <= '0;
                                state   <= DATA;
                            end
                        end
                    end
                    DATA: begin
                        if (dqs_edge) begin  // both edges carry a nibble
                            nib_cnt <= nib_cnt + 1'b1;
                            if (int'(nib_cnt) == NIBBLES_PER_WORD - 1) begin
                                rd_valid_o <= 1'b1;
                                state      <= OFF;
                            end
                        end
                    end
                    default: state <= OFF;
                endcase
            end
        end
    end

    // first nibble ends up in bits 3:0
    always_ff @(posedge clk_i) begin
        if (state == DATA && dqs_edge) rd_data_o <= {miso_sync[1], rd_data_o[31:4]};
    end

endmodule

// ==== rtl/qspi_sequencer.sv ====
`timescale 1ns/100ps

module qspi_sequencer (
    input  logic                   clk_i,
    input  logic                   nrst_i,

    input  qspi_mem_pkg::mem_req_t req_i,
    input  logic                   req_valid_i,
    output logic                   req_ready_o,
    output qspi_mem_pkg::mem_rsp_t rsp_o,
    output logic                   rsp_valid_o,
    input  logic                   rsp_ready_i,

    output logic                   cap_en_o,
    input  qspi_mem_pkg::data_w    rd_data_i,
    input  logic                   rd_valid_i,

    output logic                   spi_csn_o,
    output logic                   spi_clk_o,
    output logic [3:0]             spi_mosi_o
);
    import qspi_mem_pkg::*;

    seq_state_e                        state;
    mem_req_t                          req_q;
    data_w                             rdata_q;
    data_w                             addr_wd;
    mem_cmd_e                          cmd;
    logic [$clog2(NIBBLES_PER_WORD)-1:0] nib_cnt;
    logic [$clog2(LATENCY_CYCLES)-1:0] lat_cnt;
    logic                              clk_run;
    logic                              clk_q;
    logic                              accept;
    logic                              last_nib;

    assign req_ready_o = state == IDLE;
    assign accept      = req_valid_i && req_ready_o;
    assign clk_run     = state inside {CMD, ADDR, LATENCY, WRITE_DATA, READ_WAIT};
    assign spi_clk_o   = clk_run && clk_q;  // high phase, falls on the next edge
    assign spi_csn_o   = state inside {IDLE, RESP};
    assign cap_en_o    = state == READ_WAIT;
    assign rsp_valid_o = state == RESP;
    assign last_nib    = int'(nib_cnt) == NIBBLES_PER_WORD - 1;

    assign cmd     = req_q.is_write ? CMD_WRITE : CMD_READ;
    assign addr_wd = addr_word(req_q.addr);

    always_comb begin
        rsp_o.is_write = req_q.is_write;
        rsp_o.err      = req_q.decode_err;
        rsp_o.rdata    = rdata_q;
    end

    // nibble on the lines follows state and counter, changes at spi clock fall
    always_comb begin
        case (state)
            CMD:        spi_mosi_o = nib_cnt[0] ? cmd[3:0] : cmd[7:4];
            ADDR:       spi_mosi_o = addr_wd[{~nib_cnt, 2'b00} +: 4];  // msb first
            WRITE_DATA: spi_mosi_o = req_q.wdata[{nib_cnt, 2'b00} +: 4];  // lsb first
            default:    spi_mosi_o = 4'h0;
        endcase
    end

    always_ff @(posedge clk_i or negedge nrst_i) begin
        if (!nrst_i) begin
            state   <= IDLE;
            clk_q   <= 1'b0;
            nib_cnt <= '0;
            lat_cnt <= '0;
        end else begin
            clk_q <= clk_run ? !clk_q : 1'b0;
            case (state)
                IDLE: begin
                    if (accept) begin
                        nib_cnt <= '0;
                        state   <= req_i.decode_err ? RESP : CMD;  // no pin activity
                    end
                end
                CMD: begin
                    if (spi_clk_o) begin
                        if (nib_cnt[0]) begin
                            nib_cnt <= '0;
                            state   <= ADDR;
                        end else begin
                            nib_cnt <= nib_cnt + 1'b1;
                        end
                    end
                end
                ADDR: begin
                    if (spi_clk_o) begin
                        nib_cnt <= nib_cnt + 1'b1;  // wraps to zero
                        if (last_nib) begin
                            lat_cnt <= '0;
                            state   <= LATENCY;
                        end
                    end
                end
                LATENCY: begin
                    if (spi_clk_o) begin
                        lat_cnt <= lat_cnt + 1'b1;
                        if (int'(lat_cnt) == LATENCY_CYCLES - 1) begin
                            state <= req_q.is_write ? WRITE_DATA : READ_WAIT;
                        end
                    end
                end
                WRITE_DATA: begin
                    if (spi_clk_o) begin
                        nib_cnt <= nib_cnt + 1'b1;
                        if (last_nib) state <= TAIL;
                    end
                end
                READ_WAIT: begin
                    if (rd_valid_i) state <= RESP;
                end
                TAIL: begin
                    nib_cnt <= nib_cnt + 1'b1;  // one spi period with cs held
                    if (nib_cnt[0]) state <= RESP;
                end
                RESP: begin
                    if (rsp_ready_i) state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            req_q   <= req_i;
            rdata_q <= '0;
        end else if (state == READ_WAIT && rd_valid_i) begin
            rdata_q <= rd_data_i;
        end
    end

endmodule

// ==== rtl/req_fifo.sv ====
`timescale 1ns/100ps

module req_fifo #(
    parameter int DEPTH = qspi_mem_pkg::REQ_FIFO_DEPTH
) (
    input  logic                   clk_i,
    input  logic                   nrst_i,
    input  qspi_mem_pkg::mem_req_t push_data_i,
    input  logic                   push_valid_i,
    output logic                   push_ready_o,
    output qspi_mem_pkg::mem_req_t pop_data_o,
    output logic                   pop_valid_o,
    input  logic                   pop_ready_i
);
    import qspi_mem_pkg::*;

    mem_req_t                   mem_q [DEPTH];
    logic [$clog2(DEPTH)-1:0]   wr_ptr;
    logic [$clog2(DEPTH)-1:0]   rd_ptr;
    logic [$clog2(DEPTH+1)-1:0] count;
    logic                       push;
    logic                       pop;

    assign push_ready_o = int'(count) < DEPTH;
    assign pop_valid_o  = count != '0;
    assign pop_data_o   = mem_q[rd_ptr];
    assign push         = push_valid_i && push_ready_o;
    assign pop          = pop_valid_o && pop_ready_i;

    always_ff @(posedge clk_i or negedge nrst_i) begin
        if (!nrst_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= (int'(wr_ptr) == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            if (pop) rd_ptr <= (int'(rd_ptr) == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            if (push && !pop) count <= count + 1'b1;
            else if (pop && !push) count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) mem_q[wr_ptr] <= push_data_i;
    end

endmodule

// ==== rtl/axil_req_frontend.sv ====
`timescale 1ns/100ps

module axil_req_frontend (
    input  logic                   clk_i,
    input  logic                   nrst_i,

    input  logic [31:0]            s_awaddr_i,
    input  logic                   s_awvalid_i,
    output logic                   s_awready_o,
    input  logic [31:0]            s_wdata_i,
    input  logic [3:0]             s_wstrb_i,
    input  logic                   s_wvalid_i,
    output logic                   s_wready_o,
    output logic [1:0]             s_bresp_o,
    output logic                   s_bvalid_o,
    input  logic                   s_bready_i,
    input  logic [31:0]            s_araddr_i,
    input  logic                   s_arvalid_i,
    output logic                   s_arready_o,
    output logic [31:0]            s_rdata_o,
    output logic [1:0]             s_rresp_o,
    output logic                   s_rvalid_o,
    input  logic                   s_rready_i,

    output qspi_mem_pkg::mem_req_t req_o,
    output logic                   req_valid_o,
    input  logic                   req_ready_i,
    input  qspi_mem_pkg::mem_rsp_t rsp_i,
    input  logic                   rsp_valid_i,
    output logic                   rsp_ready_o
);
    import qspi_mem_pkg::*;

    logic        wr_pending;
    logic        take_wr;
    logic        take_rd;
    logic        rsp_take;
    logic [31:0] sel_addr;

    assign wr_pending = s_awvalid_i && s_wvalid_i;  // write wins over read
    assign take_wr    = wr_pending && req_ready_i;
    assign take_rd    = !wr_pending && s_arvalid_i && req_ready_i;
    assign sel_addr   = wr_pending ? s_awaddr_i : s_araddr_i;

    assign req_valid_o = wr_pending || s_arvalid_i;
    assign s_awready_o = take_wr;
    assign s_wready_o  = take_wr;
    assign s_arready_o = take_rd;

    always_comb begin
        req_o.is_write   = wr_pending;
        req_o.decode_err = sel_addr[31:2] >= 30'(MEM_WORDS);
        req_o.addr       = sel_addr[24:2];  // byte to word address
        req_o.wdata      = s_wdata_i;  // wstrb not applied, full words only
    end

    // only accept a response when its channel register is free
    assign rsp_ready_o = rsp_i.is_write ? !s_bvalid_o : !s_rvalid_o;
    assign rsp_take    = rsp_valid_i && rsp_ready_o;

    always_ff @(posedge clk_i or negedge nrst_i) begin
        if (!nrst_i) begin
            s_bvalid_o <= 1'b0;
            s_bresp_o  <= AXI_OKAY;
            s_rvalid_o <= 1'b0;
            s_rresp_o  <= AXI_OKAY;
            s_rdata_o  <= '0;
        end else begin
            if (rsp_take && rsp_i.is_write) begin
                s_bvalid_o <= 1'b1;
                s_bresp_o  <= rsp_i.err ? AXI_SLVERR : AXI_OKAY;
            end else if (s_bready_i) begin
                s_bvalid_o <= 1'b0;
            end

            if (rsp_take && !rsp_i.is_write) begin
                s_rvalid_o <= 1'b1;
                s_rresp_o  <= rsp_i.err ? AXI_SLVERR : AXI_OKAY;
                s_rdata_o  <= rsp_i.rdata;
            end else if (s_rready_i) begin
                s_rvalid_o <= 1'b0;
            end
        end
    end

endmodule

// ==== rtl/qspi_mem_pkg.sv ====
package qspi_mem_pkg;

    typedef enum logic [7:0] {
        CMD_WRITE = 8'h02,
        CMD_READ  = 8'h0A
    } mem_cmd_e;

    localparam int LATENCY_CYCLES   = 7;  // spi periods after the address
    localparam int PREAMBLE_EDGES   = 3;
    localparam int NIBBLES_PER_WORD = 8;
    localparam int MEM_WORDS        = 1024;
    localparam int REQ_FIFO_DEPTH   = 2;

    localparam logic [1:0] AXI_OKAY   = 2'b00;
    localparam logic [1:0] AXI_SLVERR = 2'b10;

    typedef logic [22:0] addr_w;
    typedef logic [31:0] data_w;

    typedef struct packed {
        logic  is_write;
        logic  decode_err;
        addr_w addr;
        data_w wdata;
    } mem_req_t;

    typedef struct packed {
        logic  is_write;
        logic  err;
        data_w rdata;
    } mem_rsp_t;

    typedef enum logic [2:0] {
        IDLE, CMD, ADDR, LATENCY, WRITE_DATA, READ_WAIT, TAIL, RESP
    } seq_state_e;

    typedef enum logic [1:0] {
        OFF, PREAMBLE, DATA
    } cap_state_e;

    // row and column address word as it goes out on the wire
    function automatic data_w addr_word(addr_w a);
        return {3'b000, a[22:10], 1'b0, a[9:0], 5'b00000};
    endfunction

endpackage
